// ==== stld_fwd.f ====
+incdir+verilog
verilog/lsu_types_pkg.sv
verilog/stbuf_pkg.sv
verilog/store_buffer.sv
verilog/l0_fwd_cache.sv
verilog/stld_fwd_top.sv
sim/stld_fwd_assertions.sv
sim/tb_stld_fwd.sv

// ==== Bender.yml ====
package:
  name: stld_fwd

sources:
  # design sources, packages first
  - include_dirs:
      - verilog
    files:
      - verilog/lsu_types_pkg.sv
      - verilog/stbuf_pkg.sv
      - verilog/store_buffer.sv
      - verilog/l0_fwd_cache.sv
      - verilog/stld_fwd_top.sv

  # testbench and bound checker
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/stld_fwd_assertions.sv
      - sim/tb_stld_fwd.sv

// ==== sim/tb_stld_fwd.sv ====
// forwarding testbench: directed and random stores, loads, drains and flushes
`timescale 1ns/1ns

`include "stld_fwd_cfg.svh"

module tb_stld_fwd;

  localparam int unsigned DEPTH       = `STLD_STBUF_DEPTH;
  localparam int unsigned IDX_W       = lsu_types_pkg::IDX_W;
  localparam int unsigned RESET_CYC   = 5;
  localparam int unsigned DIRECTED_CYC = 100;
  localparam int unsigned RANDOM_CYC  = 400;
  // phases plus 20 percent
  localparam int unsigned CYCLE_LIMIT = (RESET_CYC + DIRECTED_CYC + RANDOM_CYC) * 12 / 10;
  localparam int unsigned DRAIN_LIMIT = 2 * DEPTH + 4;

  // tag 0x400 idx 3, same index other tag, reserved region
  localparam lsu_types_pkg::addr_t ADDR_A  = 64'h2003;
  localparam lsu_types_pkg::addr_t ADDR_A2 = 64'h2013;
  localparam lsu_types_pkg::addr_t ADDR_R  = 64'h0043;
  // idx 5 under two tags, idx 6
  localparam lsu_types_pkg::addr_t ADDR_X  = 64'h2005;
  localparam lsu_types_pkg::addr_t ADDR_Y  = 64'h200d;
  localparam lsu_types_pkg::addr_t ADDR_Z  = 64'h3ffe;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 flush_i;
  logic                 st_push_i;
  stbuf_pkg::st_req_t   st_req_i;
  logic                 st_full_o;
  stbuf_pkg::ld_req_t   ld_req_i;
  logic                 ld_hit_o;
  lsu_types_pkg::data_t ld_value_o;
  logic                 mem_st_valid_o;
  stbuf_pkg::st_req_t   mem_st_o;
  logic                 mem_ready_i;

  string       test_name = "reset";
  int unsigned errors = 0;
  int unsigned cycles = 0;

  // reference model: buffered stores by slot, latest slot per index
  stbuf_pkg::st_req_t   m_slot [DEPTH];
  bit                   m_busy [DEPTH];
  int unsigned          m_head, m_tail, m_count;
  bit                   m_line_ok [DEPTH];
  int unsigned          m_line_slot [DEPTH];
  lsu_types_pkg::addr_t m_line_addr [DEPTH];

  stld_fwd_top dut0 (.*);

  always #50 clk_i = ~clk_i;

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------
  task automatic expect_equal(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      errors++;
      $display("mismatch test=%s check=%s expected=%h actual=%h", test_name, what, exp, act);
    end
  endtask

  // inputs change 10 ns after the edge, strobes default low
  task automatic next_edge();
    @(posedge clk_i);
    #10;
    st_push_i = 1'b0;
    flush_i   = 1'b0;
  endtask

  task automatic push_store(input lsu_types_pkg::addr_t a, input lsu_types_pkg::ldst_width_t w,
                            input lsu_types_pkg::data_t v);
    next_edge();
    st_push_i = 1'b1;
    st_req_i  = '{addr: a, width: w, value: v};
  endtask

  task automatic probe_load(input lsu_types_pkg::addr_t a, input lsu_types_pkg::ldst_width_t w);
    next_edge();
    ld_req_i = '{addr: a, width: w};
    @(negedge clk_i);
  endtask

  // memory ready until the buffer is empty
  task automatic drain_all();
    int unsigned n;
    n = 0;
    next_edge();
    mem_ready_i = 1'b1;
    @(negedge clk_i);
    while (mem_st_valid_o && n < DRAIN_LIMIT) begin
      next_edge();
      @(negedge clk_i);
      n++;
    end
    assert (!mem_st_valid_o) else begin
      errors++;
      $display("buffer did not drain within %0d cycles in test %s", DRAIN_LIMIT, test_name);
    end
    next_edge();
    mem_ready_i = 1'b0;
  endtask

  // small pools so indices alias, tag 0 lands in the reserved region
  function automatic lsu_types_pkg::addr_t pick_addr();
    lsu_types_pkg::addr_t tag;
    lsu_types_pkg::addr_t idx;
    case ($urandom_range(0, 3))
      0:       tag = 64'h400;
      1:       tag = 64'h401;
      2:       tag = 64'h7ff;
      default: tag = 64'h0;
    endcase
    idx = lsu_types_pkg::addr_t'(2 * $urandom_range(0, 3) + 1);
    return (tag << IDX_W) | idx;
  endfunction

  // ---------------------------------------------------------------------------
  // reference model, follows the driven inputs at each edge
  // ---------------------------------------------------------------------------
  always @(posedge clk_i) begin : model_update
    bit          acc;
    bit          pop;
    int unsigned line;
    if (!rst_ni || flush_i) begin
      m_head  = 0;
      m_tail  = 0;
      m_count = 0;
      for (int i = 0; i < DEPTH; i++) begin
        m_busy[i]    = 1'b0;
        m_line_ok[i] = 1'b0;
      end
    end else begin
      acc = st_push_i && (m_count < DEPTH);
      pop = mem_ready_i && (m_count > 0);
      if (pop) begin
        m_busy[m_head] = 1'b0;
        m_head = (m_head + 1) % DEPTH;
      end
      if (acc) begin
        m_slot[m_tail] = st_req_i;
        m_busy[m_tail] = 1'b1;
        // only stores outside the reserved region are recorded
        if ((st_req_i.addr & `STLD_FWD_MASK) != '0) begin
          line = st_req_i.addr[IDX_W-1:0];
          m_line_ok[line]   = 1'b1;
          m_line_slot[line] = m_tail;
          m_line_addr[line] = st_req_i.addr;
        end
        m_tail = (m_tail + 1) % DEPTH;
      end
      m_count = m_count + acc - pop;
    end
  end

  // outputs compared mid-cycle, well after the inputs settled
  always @(negedge clk_i) begin : output_check
    int unsigned          line;
    int unsigned          slot;
    bit                   exp_hit;
    lsu_types_pkg::addr_t la;
    if (rst_ni) begin
      la   = ld_req_i.addr;
      line = la[IDX_W-1:0];
      slot = m_line_slot[line];
      // line match, slot still holds a store with this tag and width
      exp_hit = m_line_ok[line] && ((m_line_addr[line] >> IDX_W) == (la >> IDX_W))
                && m_busy[slot] && ((m_slot[slot].addr >> IDX_W) == (la >> IDX_W))
                && (m_slot[slot].width == ld_req_i.width);
      expect_equal("ld_hit", exp_hit, ld_hit_o);
      if (exp_hit) begin
        expect_equal("ld_value", m_slot[slot].value, ld_value_o);
      end
      expect_equal("mem_valid", m_count != 0, mem_st_valid_o);
      expect_equal("st_full", m_count == DEPTH, st_full_o);
      // head in push order, contents untouched
      if (m_count != 0) begin
        expect_equal("mem_addr", m_slot[m_head].addr, mem_st_o.addr);
        expect_equal("mem_width", m_slot[m_head].width, mem_st_o.width);
        expect_equal("mem_value", m_slot[m_head].value, mem_st_o.value);
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles, errors=%0d", CYCLE_LIMIT, errors);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  initial begin : stimulus
    int unsigned total;
    void'($urandom(32'h0f2c_dbad));
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    st_push_i   = 1'b0;
    st_req_i    = '0;
    ld_req_i    = '0;
    mem_ready_i = 1'b0;
    repeat (RESET_CYC) @(posedge clk_i);
    #10 rst_ni = 1'b1;
    @(negedge clk_i);
    expect_equal("mem_valid", 1'b0, mem_st_valid_o);
    expect_equal("st_full", 1'b0, st_full_o);
    expect_equal("ld_hit", 1'b0, ld_hit_o);

    test_name = "fwd_same";
    push_store(ADDR_A, lsu_types_pkg::LS_WORD, 64'h1111_2222_3333_4444);
    probe_load(ADDR_A, lsu_types_pkg::LS_WORD);
    expect_equal("hit", 1'b1, ld_hit_o);
    expect_equal("value", 64'h1111_2222_3333_4444, ld_value_o);

    test_name = "no_fwd";
    probe_load(ADDR_A, lsu_types_pkg::LS_HALF);
    expect_equal("width differs", 1'b0, ld_hit_o);
    probe_load(ADDR_A2, lsu_types_pkg::LS_WORD);
    expect_equal("tag differs", 1'b0, ld_hit_o);
    push_store(ADDR_R, lsu_types_pkg::LS_DOUBLE, 64'hdead_0000_beef_0001);
    probe_load(ADDR_R, lsu_types_pkg::LS_DOUBLE);
    expect_equal("reserved", 1'b0, ld_hit_o);

    test_name = "fill_drain";
    drain_all();
    for (int i = 0; i < DEPTH; i++) begin
      push_store(pick_addr(), lsu_types_pkg::ldst_width_t'($urandom_range(0, 3)),
                 {$urandom, $urandom});
    end
    next_edge();
    @(negedge clk_i);
    expect_equal("full after depth pushes", 1'b1, st_full_o);
    drain_all();
    @(negedge clk_i);
    expect_equal("empty after drain", 1'b0, mem_st_valid_o);

    test_name = "drain_alias";
    push_store(ADDR_X, lsu_types_pkg::LS_DOUBLE, 64'h5555_0000_0000_0005);
    drain_all();
    probe_load(ADDR_X, lsu_types_pkg::LS_DOUBLE);
    expect_equal("drained", 1'b0, ld_hit_o);
    push_store(ADDR_X, lsu_types_pkg::LS_DOUBLE, 64'h5555_0000_0000_0006);
    push_store(ADDR_Y, lsu_types_pkg::LS_DOUBLE, 64'h6666_0000_0000_0007);
    probe_load(ADDR_Y, lsu_types_pkg::LS_DOUBLE);
    expect_equal("newer hit", 1'b1, ld_hit_o);
    expect_equal("newer value", 64'h6666_0000_0000_0007, ld_value_o);
    probe_load(ADDR_X, lsu_types_pkg::LS_DOUBLE);
    expect_equal("older redirected", 1'b0, ld_hit_o);

    test_name = "flush";
    push_store(ADDR_Z, lsu_types_pkg::LS_BYTE, 64'h77);
    next_edge();
    flush_i = 1'b1;
    probe_load(ADDR_Z, lsu_types_pkg::LS_BYTE);
    expect_equal("hit after flush", 1'b0, ld_hit_o);
    expect_equal("valid after flush", 1'b0, mem_st_valid_o);
    push_store(ADDR_Z, lsu_types_pkg::LS_BYTE, 64'h78);
    probe_load(ADDR_Z, lsu_types_pkg::LS_BYTE);
    expect_equal("hit after refill", 1'b1, ld_hit_o);
    expect_equal("value after refill", 64'h78, ld_value_o);

    // mixed traffic, the output check compares every cycle
    test_name = "random";
    for (int c = 0; c < RANDOM_CYC; c++) begin
      next_edge();
      flush_i     = ($urandom_range(0, 63) == 0);
      mem_ready_i = $urandom_range(0, 1);
      st_push_i   = (m_count < DEPTH) && ($urandom_range(0, 2) != 0);
      st_req_i    = '{addr: pick_addr(), width: lsu_types_pkg::ldst_width_t'($urandom_range(1, 3)),
                      value: {$urandom, $urandom}};
      ld_req_i    = '{addr: pick_addr(), width: lsu_types_pkg::ldst_width_t'($urandom_range(2, 3))};
    end
    next_edge();
    @(negedge clk_i);

    total = errors + dut0.u_assertions.fail_cnt;
    $display("errors: checks=%0d assertions=%0d total=%0d", errors,
             dut0.u_assertions.fail_cnt, total);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sim/stld_fwd_assertions.sv ====
// forwarding checker: concurrent properties on the store port, flush and fill level
`timescale 1ns/1ns

`include "stld_fwd_cfg.svh"

module stld_fwd_assertions (
  input logic                                  clk_i,
  input logic                                  rst_ni,
  input logic                                  flush_i,
  input logic                                  st_full_i,
  input logic                                  ld_hit_i,
  input logic                                  mem_st_valid_i,
  input stbuf_pkg::st_req_t                    mem_st_i,
  input logic                                  mem_ready_i,
  // buffer fill level with one bit above the slot index
  input logic [lsu_types_pkg::IDX_W:0]         count_i
);

  localparam int unsigned DEPTH = `STLD_STBUF_DEPTH;

  // assertion failure count
  int unsigned fail_cnt = 0;

  // ---------------------------------------------------------------------------
  // memory port
  // ---------------------------------------------------------------------------
  // empty buffer never offers a store
  valid_when_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (count_i == '0) |-> !mem_st_valid_i)
    else begin
      $error("store port valid while the buffer is empty");
      fail_cnt++;
    end

  // head held while memory stalls
  head_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_st_valid_i && !mem_ready_i && !flush_i) |=> $stable(mem_st_i))
    else begin
      $error("head store changed while the memory port was stalled");
      fail_cnt++;
    end

  // ---------------------------------------------------------------------------
  // flush and fill level
  // ---------------------------------------------------------------------------
  no_hit_after_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !ld_hit_i)
    else begin
      $error("load forwarded in the cycle after a flush");
      fail_cnt++;
    end

  // full buffer holds at depth or drops by one on a pop
  count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (st_full_i && !flush_i) |=> (count_i == DEPTH - $past(mem_ready_i)))
    else begin
      $error("fill level went wrong after the buffer was full");
      fail_cnt++;
    end

endmodule

// checker sits inside the top and sees the buffer count directly
bind stld_fwd_top stld_fwd_assertions u_assertions (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .flush_i        (flush_i),
  .st_full_i      (st_full_o),
  .ld_hit_i       (ld_hit_o),
  .mem_st_valid_i (mem_st_valid_o),
  .mem_st_i       (mem_st_o),
  .mem_ready_i    (mem_ready_i),
  .count_i        (u_store_buffer.count_q)
);

// ==== verilog/stld_fwd_top.sv ====
// store-to-load forwarding top: store buffer plus level-zero forwarding cache
`timescale 1ns/1ns

module stld_fwd_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,

  // store push
  input  logic                 st_push_i,
  input  stbuf_pkg::st_req_t   st_req_i,
  output logic                 st_full_o,

  // load probe
  input  stbuf_pkg::ld_req_t   ld_req_i,
  output logic                 ld_hit_o,
  output lsu_types_pkg::data_t ld_value_o,

  // memory port
  output logic                 mem_st_valid_o,
  output stbuf_pkg::st_req_t   mem_st_o,
  input  logic                 mem_ready_i
);

  // ---------------------------------------------------------------------------
  // buffer <-> cache wires
  // ---------------------------------------------------------------------------
  logic                      rec_valid;
  lsu_types_pkg::stbuf_idx_t rec_idx;
  lsu_types_pkg::stbuf_idx_t rd_idx;
  stbuf_pkg::stbuf_rd_t      rd;

  // store buffer
  store_buffer u_store_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .push_i      (st_push_i),
    .st_req_i    (st_req_i),
    .full_o      (st_full_o),
    .rec_valid_o (rec_valid),
    .rec_idx_o   (rec_idx),
    .rd_idx_i    (rd_idx),
    .rd_o        (rd),
    .mem_valid_o (mem_st_valid_o),
    .mem_st_o    (mem_st_o),
    .mem_ready_i (mem_ready_i)
  );

  // forwarding cache, store address taken from the push request
  l0_fwd_cache u_l0_cache (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .rec_valid_i (rec_valid),
    .st_addr_i   (st_req_i.addr),
    .rec_idx_i   (rec_idx),
    .ld_req_i    (ld_req_i),
    .rd_idx_o    (rd_idx),
    .rd_i        (rd),
    .ld_hit_o    (ld_hit_o),
    .ld_value_o  (ld_value_o)
  );

endmodule

// ==== verilog/l0_fwd_cache.sv ====
// level-zero forwarding cache: maps an address index to the latest store slot
`timescale 1ns/1ns

`include "stld_fwd_cfg.svh"

module l0_fwd_cache (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,

  // store record from the buffer
  input  logic                      rec_valid_i,
  input  lsu_types_pkg::addr_t      st_addr_i,
  input  lsu_types_pkg::stbuf_idx_t rec_idx_i,

  // load probe
  input  stbuf_pkg::ld_req_t        ld_req_i,

  // buffer read port
  output lsu_types_pkg::stbuf_idx_t rd_idx_o,
  input  stbuf_pkg::stbuf_rd_t      rd_i,

  // forwarding result
  output logic                      ld_hit_o,
  output lsu_types_pkg::data_t      ld_value_o
);

  // ---------------------------------------------------------------------------
  // sizes and line layout
  // ---------------------------------------------------------------------------
  localparam int unsigned LINES = `STLD_STBUF_DEPTH;
  localparam int unsigned IDX_W = lsu_types_pkg::IDX_W;
  localparam int unsigned TAG_W = lsu_types_pkg::TAG_W;
  localparam int unsigned XLEN  = lsu_types_pkg::XLEN;

  // line payload, valid bits kept apart
  typedef struct packed {
    lsu_types_pkg::fwd_tag_t   tag;
    lsu_types_pkg::stbuf_idx_t slot;
  } l0_line_t;

  logic [LINES-1:0] line_valid_q;
  l0_line_t         lines_q [LINES];

  // store side decode
  lsu_types_pkg::stbuf_idx_t st_idx;
  lsu_types_pkg::fwd_tag_t   st_tag;
  logic                      st_fwd_ok;
  logic                      line_upd;

  // load side decode
  lsu_types_pkg::stbuf_idx_t ld_idx;
  lsu_types_pkg::fwd_tag_t   ld_tag;
  logic                      line_hit;
  logic                      buf_hit;

  // ---------------------------------------------------------------------------
  // line update
  // ---------------------------------------------------------------------------
  // reserved region: masked address all zero
  assign st_fwd_ok = (st_addr_i & `STLD_FWD_MASK) != '0;
  assign line_upd  = rec_valid_i & st_fwd_ok;
  assign st_idx    = st_addr_i[IDX_W-1:0];
  assign st_tag    = st_addr_i[XLEN-1 -: TAG_W];

  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_update
    if (!rst_ni) begin
      line_valid_q <= '0;
    end else if (flush_i) begin
      line_valid_q <= '0;
    end else if (line_upd) begin
      line_valid_q[st_idx] <= 1'b1;
    end
  end

  // newest store on this index overwrites the line
  always_ff @(posedge clk_i) begin : line_update
    if (line_upd && !flush_i) begin
      lines_q[st_idx].tag  <= st_tag;
      lines_q[st_idx].slot <= rec_idx_i;
    end
  end

  // ---------------------------------------------------------------------------
  // lookup
  // ---------------------------------------------------------------------------
  assign ld_idx   = ld_req_i.addr[IDX_W-1:0];
  assign ld_tag   = ld_req_i.addr[XLEN-1 -: TAG_W];

  // address recorded in the cache
  assign line_hit = line_valid_q[ld_idx] & (lines_q[ld_idx].tag == ld_tag);

  // slot still holds that store, same size
  // guards against a reused or drained slot
  assign buf_hit  = rd_i.cached & (rd_i.tag == ld_tag) & (rd_i.width == ld_req_i.width);

  // ---------------------------------------------------------------------------
  // outputs
  // ---------------------------------------------------------------------------
  assign rd_idx_o   = lines_q[ld_idx].slot;
  assign ld_hit_o   = line_hit & buf_hit;
  assign ld_value_o = rd_i.value;

endmodule

// ==== verilog/store_buffer.sv ====
// store buffer: circular FIFO of stores in program order, drained oldest first
`timescale 1ns/1ns

`include "stld_fwd_cfg.svh"

module store_buffer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // exception flush drops every buffered store
  input  logic                     flush_i,

  // store side
  input  logic                     push_i,
  input  stbuf_pkg::st_req_t       st_req_i,
  output logic                     full_o,

  // record strobe to the level-zero cache
  output logic                     rec_valid_o,
  output lsu_types_pkg::stbuf_idx_t rec_idx_o,

  // indexed read port for forwarding
  input  lsu_types_pkg::stbuf_idx_t rd_idx_i,
  output stbuf_pkg::stbuf_rd_t     rd_o,

  // memory port
  output logic                     mem_valid_o,
  output stbuf_pkg::st_req_t       mem_st_o,
  input  logic                     mem_ready_i
);

  // ---------------------------------------------------------------------------
  // sizes
  // ---------------------------------------------------------------------------
  localparam int unsigned DEPTH = `STLD_STBUF_DEPTH;
  localparam int unsigned IDX_W = lsu_types_pkg::IDX_W;
  localparam int unsigned TAG_W = lsu_types_pkg::TAG_W;
  localparam int unsigned XLEN  = lsu_types_pkg::XLEN;

  // count needs one more bit than the index to hold DEPTH
  typedef logic [IDX_W:0] cnt_t;

  // ---------------------------------------------------------------------------
  // state
  // ---------------------------------------------------------------------------
  stbuf_pkg::stbuf_entry_t   entries_q [DEPTH];
  // next slot to drain
  lsu_types_pkg::stbuf_idx_t head_q;
  // next slot to fill
  lsu_types_pkg::stbuf_idx_t tail_q;
  cnt_t                      count_q;

  // control
  logic empty;
  logic push_ok;
  logic pop;

  // ---------------------------------------------------------------------------
  // status and handshake strobes
  // ---------------------------------------------------------------------------
  assign empty   = (count_q == '0);
  assign full_o  = (count_q == cnt_t'(DEPTH));

  // push dropped when full or flushing
  assign push_ok = push_i & ~full_o & ~flush_i;
  // memory takes the head on ready
  assign pop     = ~empty & mem_ready_i;

  // tell the cache where this store lands
  assign rec_valid_o = push_ok;
  assign rec_idx_o   = tail_q;

  // ---------------------------------------------------------------------------
  // pointers and count
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : ptr_update
    if (!rst_ni) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      // pointers wrap by themselves on a power-of-two depth
      if (push_ok) begin
        tail_q <= tail_q + 1'b1;
      end
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      // push and pop together leave count unchanged
      case ({push_ok, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // slot array
  // ---------------------------------------------------------------------------
  // valid bits cleared on reset and flush
  always_ff @(posedge clk_i or negedge rst_ni) begin : entry_write
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        entries_q[i].valid <= 1'b0;
      end
    end else if (flush_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        entries_q[i].valid <= 1'b0;
      end
    end else begin
      // retire the drained slot
      // head and tail differ whenever both strobes are high
      if (pop) begin
        entries_q[head_q].valid <= 1'b0;
      end
      // new store at the tail
      if (push_ok) begin
        entries_q[tail_q].valid <= 1'b1;
        entries_q[tail_q].addr  <= st_req_i.addr;
        entries_q[tail_q].width <= st_req_i.width;
        entries_q[tail_q].value <= st_req_i.value;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // indexed read port
  // ---------------------------------------------------------------------------
  // cached drops as soon as the slot drains or is flushed
  always_comb begin : rd_port
    rd_o.cached = entries_q[rd_idx_i].valid;
    // tag is the address above the cache index
    rd_o.tag    = entries_q[rd_idx_i].addr[XLEN-1 -: TAG_W];
    rd_o.width  = entries_q[rd_idx_i].width;
    rd_o.value  = entries_q[rd_idx_i].value;
  end

  // ---------------------------------------------------------------------------
  // memory port
  // ---------------------------------------------------------------------------
  // head slot shown straight from the array
  assign mem_valid_o = ~empty;

  always_comb begin : mem_port
    mem_st_o.addr  = entries_q[head_q].addr;
    mem_st_o.width = entries_q[head_q].width;
    mem_st_o.value = entries_q[head_q].value;
  end

endmodule

// ==== verilog/stbuf_pkg.sv ====
// store buffer bundles: store and load requests, buffer slots, index read answer
package stbuf_pkg;

  // ---------------------------------------------------------------------------
  // requests from the pipeline
  // ---------------------------------------------------------------------------
  // store: address, size and value
  typedef struct packed {
    lsu_types_pkg::addr_t       addr;
    lsu_types_pkg::ldst_width_t width;
    lsu_types_pkg::data_t       value;
  } st_req_t;

  // load probe: address and size only
  typedef struct packed {
    lsu_types_pkg::addr_t       addr;
    lsu_types_pkg::ldst_width_t width;
  } ld_req_t;

  // ---------------------------------------------------------------------------
  // buffer internals and read port
  // ---------------------------------------------------------------------------
  // one buffer slot
  typedef struct packed {
    logic                       valid;
    lsu_types_pkg::addr_t       addr;
    lsu_types_pkg::ldst_width_t width;
    lsu_types_pkg::data_t       value;
  } stbuf_entry_t;

  // answer to an index read from the cache
  typedef struct packed {
    logic                       cached;
    lsu_types_pkg::fwd_tag_t    tag;
    lsu_types_pkg::ldst_width_t width;
    lsu_types_pkg::data_t       value;
  } stbuf_rd_t;

endpackage

// ==== verilog/lsu_types_pkg.sv ====
// load/store unit base types: addresses, data, access widths and slot indices
package lsu_types_pkg;

  `include "stld_fwd_cfg.svh"

  // ---------------------------------------------------------------------------
  // derived sizes
  // ---------------------------------------------------------------------------
  localparam int unsigned XLEN        = `STLD_XLEN;
  localparam int unsigned STBUF_DEPTH = `STLD_STBUF_DEPTH;
  // slot index width, also the cache index width
  localparam int unsigned IDX_W       = $clog2(STBUF_DEPTH);
  // address bits above the cache index
  localparam int unsigned TAG_W       = XLEN - IDX_W;

  // ---------------------------------------------------------------------------
  // types
  // ---------------------------------------------------------------------------
  typedef logic [XLEN-1:0]  addr_t;
  typedef logic [XLEN-1:0]  data_t;
  typedef logic [IDX_W-1:0] stbuf_idx_t;
  typedef logic [TAG_W-1:0] fwd_tag_t;

  // access size of a load or store
  typedef enum logic [1:0] {
    LS_BYTE   = 2'b00,
    LS_HALF   = 2'b01,
    LS_WORD   = 2'b10,
    LS_DOUBLE = 2'b11
  } ldst_width_t;

endpackage

// ==== verilog/stld_fwd_cfg.svh ====
// store-to-load forwarding configuration: data width, buffer depth, reserved mask
`ifndef STLD_FWD_CFG_SVH
`define STLD_FWD_CFG_SVH

// ---------------------------------------------------------------------------
// datapath
// ---------------------------------------------------------------------------
// address and data width in bits
`define STLD_XLEN 64

// ---------------------------------------------------------------------------
// store buffer and level-zero cache
// ---------------------------------------------------------------------------
// slot count, power of two, also the number of cache lines
`define STLD_STBUF_DEPTH 8

// store address & mask == 0 means reserved region, never cached
`define STLD_FWD_MASK 64'hffff_ffff_ffff_ff00

`endif
